/* ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// number of reservation station entries
// works with 4, 8 or 16
`define OOO_RS_DEPTH 8

// rob tag width for up to 32 in-flight instructions
`define OOO_TAG_W 5

// datapath width
`define OOO_XLEN 32

`endif

/* ooo_types_pkg.sv */
`include "ooo_settings.svh"

package ooo_types_pkg;

    // one data word on the datapath and cdb
    typedef logic [`OOO_XLEN-1:0] word_t;

    // rob tag carried with every instruction
    typedef logic [`OOO_TAG_W-1:0] rob_tag_t;

    // execution opcodes with OP_MUL reserved for the multiplier
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } alu_op_e;

    // reservation station entry state
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WAIT  = 2'd1,
        ST_READY = 2'd2
    } rs_state_e;

endpackage

/* reservation_station.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reservation_station #(
    parameter int DEPTH = `OOO_RS_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    output logic                      dispatch_ready,
    input  ooo_types_pkg::alu_op_e    dispatch_op,
    input  ooo_types_pkg::rob_tag_t   dispatch_tag,
    input  ooo_types_pkg::word_t      src1_value,
    input  logic                      src1_ready,
    input  ooo_types_pkg::rob_tag_t   src1_tag,
    input  ooo_types_pkg::word_t      src2_value,
    input  logic                      src2_ready,
    input  ooo_types_pkg::rob_tag_t   src2_tag,
    input  logic                      cdb_valid,
    input  ooo_types_pkg::rob_tag_t   cdb_tag,
    input  ooo_types_pkg::word_t      cdb_data,
    output logic                      alu_issue_valid,
    input  logic                      alu_issue_ready,
    output ooo_types_pkg::alu_op_e    alu_issue_op,
    output ooo_types_pkg::rob_tag_t   alu_issue_tag,
    output ooo_types_pkg::word_t      alu_issue_a,
    output ooo_types_pkg::word_t      alu_issue_b,
    output logic                      mul_issue_valid,
    input  logic                      mul_issue_ready,
    output ooo_types_pkg::rob_tag_t   mul_issue_tag,
    output ooo_types_pkg::word_t      mul_issue_a,
    output ooo_types_pkg::word_t      mul_issue_b
);

    localparam int IDX_W = $clog2(DEPTH);

    ooo_types_pkg::rs_state_e  state   [DEPTH];
    ooo_types_pkg::alu_op_e    op      [DEPTH];
    ooo_types_pkg::rob_tag_t   tag     [DEPTH];
    ooo_types_pkg::word_t      op1_val [DEPTH];
    ooo_types_pkg::word_t      op2_val [DEPTH];
    ooo_types_pkg::rob_tag_t   op1_tag [DEPTH];
    ooo_types_pkg::rob_tag_t   op2_tag [DEPTH];
    logic                      op1_rdy [DEPTH];
    logic                      op2_rdy [DEPTH];

    logic [DEPTH-1:0] free_vec;
    logic [DEPTH-1:0] alu_rdy_vec;
    logic [DEPTH-1:0] mul_rdy_vec;
    logic [DEPTH-1:0] hit1;
    logic [DEPTH-1:0] hit2;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] alu_idx;
    logic [IDX_W-1:0] mul_idx;

    logic dispatch_fire;
    logic alu_fire;
    logic mul_fire;
    logic d1_rdy;
    logic d2_rdy;

    // priority encoder where the lowest set bit wins
    function automatic logic [IDX_W-1:0] lowest_set(input logic [DEPTH-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            free_vec[i]    = (state[i] == ooo_types_pkg::ST_IDLE);
            alu_rdy_vec[i] = (state[i] == ooo_types_pkg::ST_READY) &&
                             (op[i] != ooo_types_pkg::OP_MUL);
            mul_rdy_vec[i] = (state[i] == ooo_types_pkg::ST_READY) &&
                             (op[i] == ooo_types_pkg::OP_MUL);
            // cdb wakeup of missing operands
            hit1[i] = cdb_valid && (state[i] == ooo_types_pkg::ST_WAIT) &&
                      !op1_rdy[i] && (op1_tag[i] == cdb_tag);
            hit2[i] = cdb_valid && (state[i] == ooo_types_pkg::ST_WAIT) &&
                      !op2_rdy[i] && (op2_tag[i] == cdb_tag);
        end
    end

    assign free_idx = lowest_set(free_vec);
    assign alu_idx  = lowest_set(alu_rdy_vec);
    assign mul_idx  = lowest_set(mul_rdy_vec);

    assign dispatch_ready = |free_vec;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    // a result on the cdb this cycle also satisfies the incoming operands
    assign d1_rdy = src1_ready || (cdb_valid && (src1_tag == cdb_tag));
    assign d2_rdy = src2_ready || (cdb_valid && (src2_tag == cdb_tag));

    assign alu_issue_valid = |alu_rdy_vec;
    assign alu_issue_op    = op[alu_idx];
    assign alu_issue_tag   = tag[alu_idx];
    assign alu_issue_a     = op1_val[alu_idx];
    assign alu_issue_b     = op2_val[alu_idx];
    assign alu_fire        = alu_issue_valid && alu_issue_ready;

    assign mul_issue_valid = |mul_rdy_vec;
    assign mul_issue_tag   = tag[mul_idx];
    assign mul_issue_a     = op1_val[mul_idx];
    assign mul_issue_b     = op2_val[mul_idx];
    assign mul_fire        = mul_issue_valid && mul_issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= ooo_types_pkg::ST_IDLE;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (dispatch_fire && (free_idx == IDX_W'(i))) begin
                    state[i] <= (d1_rdy && d2_rdy) ? ooo_types_pkg::ST_READY
                                                   : ooo_types_pkg::ST_WAIT;
                end else if ((alu_fire && (alu_idx == IDX_W'(i))) ||
                             (mul_fire && (mul_idx == IDX_W'(i)))) begin
                    state[i] <= ooo_types_pkg::ST_IDLE;
                end else if ((state[i] == ooo_types_pkg::ST_WAIT) &&
                             (op1_rdy[i] || hit1[i]) && (op2_rdy[i] || hit2[i])) begin
                    // last missing operand arrives
                    state[i] <= ooo_types_pkg::ST_READY;
                end
            end
        end
    end

    // entry payload is only meaningful while the entry is not idle
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (dispatch_fire && (free_idx == IDX_W'(i))) begin
                op[i]      <= dispatch_op;
                tag[i]     <= dispatch_tag;
                op1_tag[i] <= src1_tag;
                op2_tag[i] <= src2_tag;
                op1_rdy[i] <= d1_rdy;
                op2_rdy[i] <= d2_rdy;
                op1_val[i] <= src1_ready ? src1_value : cdb_data;
                op2_val[i] <= src2_ready ? src2_value : cdb_data;
            end else begin
                if (hit1[i]) begin
                    op1_val[i] <= cdb_data;
                    op1_rdy[i] <= 1'b1;
                end
                if (hit2[i]) begin
                    op2_val[i] <= cdb_data;
                    op2_rdy[i] <= 1'b1;
                end
            end
        end
    end

endmodule

/* int_alu_unit.sv */
`timescale 1ns/1ps

module int_alu_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  ooo_types_pkg::alu_op_e    issue_op,
    input  ooo_types_pkg::rob_tag_t   issue_tag,
    input  ooo_types_pkg::word_t      issue_a,
    input  ooo_types_pkg::word_t      issue_b,
    output logic                      res_valid,
    input  logic                      res_ready,
    output ooo_types_pkg::rob_tag_t   res_tag,
    output ooo_types_pkg::word_t      res_data
);

    ooo_types_pkg::word_t alu_out;

    always_comb begin
        case (issue_op)
            ooo_types_pkg::OP_ADD: alu_out = issue_a + issue_b;
            ooo_types_pkg::OP_SUB: alu_out = issue_a - issue_b;
            ooo_types_pkg::OP_AND: alu_out = issue_a & issue_b;
            ooo_types_pkg::OP_OR:  alu_out = issue_a | issue_b;
            ooo_types_pkg::OP_XOR: alu_out = issue_a ^ issue_b;
            // shift amount from the low five bits
            ooo_types_pkg::OP_SLL: alu_out = issue_a << issue_b[4:0];
            ooo_types_pkg::OP_SRL: alu_out = issue_a >> issue_b[4:0];
            // multiplies never reach this unit
            default:               alu_out = '0;
        endcase
    end

    // output stage frees up when empty or granted this cycle
    assign issue_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (issue_ready) begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            res_tag  <= issue_tag;
            res_data <= alu_out;
        end
    end

endmodule

/* mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  ooo_types_pkg::rob_tag_t   issue_tag,
    input  ooo_types_pkg::word_t      issue_a,
    input  ooo_types_pkg::word_t      issue_b,
    output logic                      res_valid,
    input  logic                      res_ready,
    output ooo_types_pkg::rob_tag_t   res_tag,
    output ooo_types_pkg::word_t      res_data
);

    logic                      s1_valid;
    ooo_types_pkg::rob_tag_t   s1_tag;
    ooo_types_pkg::word_t      s1_a;
    ooo_types_pkg::word_t      s1_b;
    ooo_types_pkg::word_t      product;
    logic                      advance;

    // low half of the product only
    assign product = s1_a * s1_b;

    // stage two moves on when empty or granted
    assign advance = !res_valid || res_ready;

    // stage one still takes a new op into a bubble during a stall
    assign issue_ready = advance || !s1_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (issue_ready) begin
                s1_valid <= issue_valid;
            end
            if (advance) begin
                res_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            s1_tag <= issue_tag;
            s1_a   <= issue_a;
            s1_b   <= issue_b;
        end
        if (advance && s1_valid) begin
            res_tag  <= s1_tag;
            res_data <= product;
        end
    end

endmodule

/* cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alu_res_valid,
    output logic                      alu_res_ready,
    input  ooo_types_pkg::rob_tag_t   alu_res_tag,
    input  ooo_types_pkg::word_t      alu_res_data,
    input  logic                      mul_res_valid,
    output logic                      mul_res_ready,
    input  ooo_types_pkg::rob_tag_t   mul_res_tag,
    input  ooo_types_pkg::word_t      mul_res_data,
    output logic                      cdb_valid,
    output ooo_types_pkg::rob_tag_t   cdb_tag,
    output ooo_types_pkg::word_t      cdb_data
);

    // set when the multiplier won the last grant
    logic last_mul;

    // alu wins unless the multiplier also asks and the alu went last
    assign alu_res_ready = alu_res_valid && (!mul_res_valid || last_mul);
    assign mul_res_ready = mul_res_valid && !alu_res_ready;

    assign cdb_valid = alu_res_ready || mul_res_ready;
    assign cdb_tag   = alu_res_ready ? alu_res_tag  : mul_res_tag;
    assign cdb_data  = alu_res_ready ? alu_res_data : mul_res_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul <= 1'b0;
        end else if (cdb_valid) begin
            last_mul <= mul_res_ready;
        end
    end

endmodule

/* ooo_backend.sv */
`timescale 1ns/1ps

module ooo_backend (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    output logic                      dispatch_ready,
    input  ooo_types_pkg::alu_op_e    dispatch_op,
    input  ooo_types_pkg::rob_tag_t   dispatch_tag,
    input  ooo_types_pkg::word_t      src1_value,
    input  logic                      src1_ready,
    input  ooo_types_pkg::rob_tag_t   src1_tag,
    input  ooo_types_pkg::word_t      src2_value,
    input  logic                      src2_ready,
    input  ooo_types_pkg::rob_tag_t   src2_tag,
    output logic                      cdb_valid,
    output ooo_types_pkg::rob_tag_t   cdb_tag,
    output ooo_types_pkg::word_t      cdb_data
);

    // station to alu
    logic                      alu_issue_valid;
    logic                      alu_issue_ready;
    ooo_types_pkg::alu_op_e    alu_issue_op;
    ooo_types_pkg::rob_tag_t   alu_issue_tag;
    ooo_types_pkg::word_t      alu_issue_a;
    ooo_types_pkg::word_t      alu_issue_b;

    // station to multiplier
    logic                      mul_issue_valid;
    logic                      mul_issue_ready;
    ooo_types_pkg::rob_tag_t   mul_issue_tag;
    ooo_types_pkg::word_t      mul_issue_a;
    ooo_types_pkg::word_t      mul_issue_b;

    // unit results into the arbiter
    logic                      alu_res_valid;
    logic                      alu_res_ready;
    ooo_types_pkg::rob_tag_t   alu_res_tag;
    ooo_types_pkg::word_t      alu_res_data;
    logic                      mul_res_valid;
    logic                      mul_res_ready;
    ooo_types_pkg::rob_tag_t   mul_res_tag;
    ooo_types_pkg::word_t      mul_res_data;

    reservation_station reservation_station_inst (
        .clk             (clk),
        .rst             (rst),
        .dispatch_valid  (dispatch_valid),
        .dispatch_ready  (dispatch_ready),
        .dispatch_op     (dispatch_op),
        .dispatch_tag    (dispatch_tag),
        .src1_value      (src1_value),
        .src1_ready      (src1_ready),
        .src1_tag        (src1_tag),
        .src2_value      (src2_value),
        .src2_ready      (src2_ready),
        .src2_tag        (src2_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_data        (cdb_data),
        .alu_issue_valid (alu_issue_valid),
        .alu_issue_ready (alu_issue_ready),
        .alu_issue_op    (alu_issue_op),
        .alu_issue_tag   (alu_issue_tag),
        .alu_issue_a     (alu_issue_a),
        .alu_issue_b     (alu_issue_b),
        .mul_issue_valid (mul_issue_valid),
        .mul_issue_ready (mul_issue_ready),
        .mul_issue_tag   (mul_issue_tag),
        .mul_issue_a     (mul_issue_a),
        .mul_issue_b     (mul_issue_b)
    );

    int_alu_unit int_alu_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (alu_issue_valid),
        .issue_ready (alu_issue_ready),
        .issue_op    (alu_issue_op),
        .issue_tag   (alu_issue_tag),
        .issue_a     (alu_issue_a),
        .issue_b     (alu_issue_b),
        .res_valid   (alu_res_valid),
        .res_ready   (alu_res_ready),
        .res_tag     (alu_res_tag),
        .res_data    (alu_res_data)
    );

    mul_unit mul_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (mul_issue_valid),
        .issue_ready (mul_issue_ready),
        .issue_tag   (mul_issue_tag),
        .issue_a     (mul_issue_a),
        .issue_b     (mul_issue_b),
        .res_valid   (mul_res_valid),
        .res_ready   (mul_res_ready),
        .res_tag     (mul_res_tag),
        .res_data    (mul_res_data)
    );

    // cdb feeds the station wakeup and the top-level outputs
    cdb_arbiter cdb_arbiter_inst (
        .clk           (clk),
        .rst           (rst),
        .alu_res_valid (alu_res_valid),
        .alu_res_ready (alu_res_ready),
        .alu_res_tag   (alu_res_tag),
        .alu_res_data  (alu_res_data),
        .mul_res_valid (mul_res_valid),
        .mul_res_ready (mul_res_ready),
        .mul_res_tag   (mul_res_tag),
        .mul_res_data  (mul_res_data),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data)
    );

endmodule

/* tb_ooo_backend.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module tb_ooo_backend;

    localparam int NUM_TAGS   = 1 << `OOO_TAG_W;
    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 40;

    logic                      clk;
    logic                      rst;
    logic                      dispatch_valid;
    logic                      dispatch_ready;
    ooo_types_pkg::alu_op_e    dispatch_op;
    ooo_types_pkg::rob_tag_t   dispatch_tag;
    ooo_types_pkg::word_t      src1_value;
    logic                      src1_ready;
    ooo_types_pkg::rob_tag_t   src1_tag;
    ooo_types_pkg::word_t      src2_value;
    logic                      src2_ready;
    ooo_types_pkg::rob_tag_t   src2_tag;
    logic                      cdb_valid;
    ooo_types_pkg::rob_tag_t   cdb_tag;
    ooo_types_pkg::word_t      cdb_data;

    integer seed;
    int     cycle_count;
    int     pending_count;
    int     generated;
    int     shift_amt;
    logic   holding;
    logic   fire;
    logic   saw_full;
    logic   pending  [NUM_TAGS];
    ooo_types_pkg::word_t    expected [NUM_TAGS];
    ooo_types_pkg::rob_tag_t next_tag;
    ooo_types_pkg::rob_tag_t last_tag;
    logic                    prev_cdb_valid;
    ooo_types_pkg::rob_tag_t prev_cdb_tag;
    ooo_types_pkg::word_t    prev_cdb_data;

    ooo_backend ooo_backend_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .src1_value     (src1_value),
        .src1_ready     (src1_ready),
        .src1_tag       (src1_tag),
        .src2_value     (src2_value),
        .src2_ready     (src2_ready),
        .src2_tag       (src2_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            stop_with_error("timeout: not every dispatched instruction was broadcast in time");
        end
    end

    // reference rules for each operation
    function automatic ooo_types_pkg::word_t model_result(input ooo_types_pkg::alu_op_e op,
                                                          input ooo_types_pkg::word_t a,
                                                          input ooo_types_pkg::word_t b);
        case (op)
            ooo_types_pkg::OP_ADD: return a + b;
            ooo_types_pkg::OP_SUB: return a - b;
            ooo_types_pkg::OP_AND: return a & b;
            ooo_types_pkg::OP_OR:  return a | b;
            ooo_types_pkg::OP_XOR: return a ^ b;
            ooo_types_pkg::OP_SLL: return a << b[4:0];
            ooo_types_pkg::OP_SRL: return a >> b[4:0];
            default:               return a * b;
        endcase
    endfunction

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("ERROR @ %0t ns: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_tag_known(input ooo_types_pkg::rob_tag_t t);
        if (!pending[t]) begin
            stop_with_error($sformatf("ERROR @ %0t ns: broadcast of tag %0d with nothing pending",
                                      $time, t));
        end
    endtask

    task automatic check_result(input ooo_types_pkg::rob_tag_t t, input ooo_types_pkg::word_t d);
        if (d !== expected[t]) begin
            stop_with_error($sformatf("ERROR @ %0t ns: tag %0d broadcast %h, model %h",
                                      $time, t, d, expected[t]));
        end
        pending[t] = 1'b0;
        pending_count--;
    endtask

    // ready random value, or the first pending producer found from start
    task automatic pick_source(input logic want_dep, input ooo_types_pkg::rob_tag_t start,
                               output logic rdy, output ooo_types_pkg::rob_tag_t t,
                               output ooo_types_pkg::word_t drive_v,
                               output ooo_types_pkg::word_t model_v);
        ooo_types_pkg::rob_tag_t probe;
        rdy     = 1'b1;
        t       = '0;
        drive_v = $random(seed);
        model_v = drive_v;
        for (int i = 0; i < NUM_TAGS; i++) begin
            probe = start + ooo_types_pkg::rob_tag_t'(i);
            if (want_dep && rdy && pending[probe]) begin
                rdy     = 1'b0;
                t       = probe;
                model_v = expected[probe];
            end
        end
    endtask

    initial begin
        logic [31:0]            rnd;
        logic                   chain;
        ooo_types_pkg::word_t   a_val;
        ooo_types_pkg::word_t   b_val;
        ooo_types_pkg::alu_op_e op;
        seed           = 36765;
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = ooo_types_pkg::OP_ADD;
        dispatch_tag   = '0;
        src1_value     = '0;
        src1_ready     = 1'b0;
        src1_tag       = '0;
        src2_value     = '0;
        src2_ready     = 1'b0;
        src2_tag       = '0;
        cycle_count    = 0;
        pending_count  = 0;
        generated      = 0;
        shift_amt      = 0;
        holding        = 1'b0;
        fire           = 1'b0;
        saw_full       = 1'b0;
        next_tag       = '0;
        last_tag       = '0;
        prev_cdb_valid = 1'b0;
        prev_cdb_tag   = '0;
        prev_cdb_data  = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            pending[i]  = 1'b0;
            expected[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        // quiet bus and open dispatch before anything is sent
        repeat (4) begin
            @(posedge clk);
            #1;
            check_flag(cdb_valid, 1'b0, "cdb_valid after reset");
            check_flag(dispatch_ready, 1'b1, "dispatch_ready after reset");
        end
        while (generated < NUM_INSTR || holding || pending_count != 0) begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            if (fire) begin
                holding = 1'b0;
            end else if (holding && prev_cdb_valid) begin
                // producer went by while we waited, so its value is now known
                if (!src1_ready && src1_tag == prev_cdb_tag) begin
                    src1_ready = 1'b1;
                    src1_value = prev_cdb_data;
                end
                if (!src2_ready && src2_tag == prev_cdb_tag) begin
                    src2_ready = 1'b1;
                    src2_value = prev_cdb_data;
                end
            end
            // long mul chains in the middle of the stream
            chain = (generated >= 200) && (generated < 260);
            if (!holding && generated < NUM_INSTR && !pending[next_tag] &&
                (chain || rnd[31:29] != 3'd0)) begin
                op = chain ? ooo_types_pkg::OP_MUL : ooo_types_pkg::alu_op_e'(rnd[2:0]);
                pick_source(chain || (generated >= 100 && rnd[3]),
                            chain ? last_tag : ooo_types_pkg::rob_tag_t'(rnd[15:8]),
                            src1_ready, src1_tag, src1_value, a_val);
                pick_source(!chain && generated >= 100 && rnd[4],
                            ooo_types_pkg::rob_tag_t'(rnd[23:16]),
                            src2_ready, src2_tag, src2_value, b_val);
                if ((op == ooo_types_pkg::OP_SLL || op == ooo_types_pkg::OP_SRL) &&
                    src2_ready) begin
                    // walk the shift amount through 0 to 31
                    src2_value[4:0] = shift_amt[4:0];
                    b_val           = src2_value;
                    shift_amt++;
                end
                dispatch_op        = op;
                dispatch_tag       = next_tag;
                expected[next_tag] = model_result(op, a_val, b_val);
                pending[next_tag]  = 1'b1;
                pending_count++;
                last_tag = next_tag;
                next_tag = next_tag + 1'b1;
                generated++;
                holding = 1'b1;
            end
            dispatch_valid = holding;
            if (holding && !dispatch_ready) begin
                saw_full = 1'b1;
            end
            fire           = dispatch_valid && dispatch_ready;
            prev_cdb_valid = cdb_valid;
            prev_cdb_tag   = cdb_tag;
            prev_cdb_data  = cdb_data;
            if (cdb_valid) begin
                check_tag_known(cdb_tag);
                check_result(cdb_tag, cdb_data);
            end
        end
        // no late or repeated broadcast once the model is empty
        repeat (8) begin
            @(posedge clk);
            #1;
            check_flag(cdb_valid, 1'b0, "cdb_valid after the last result");
            check_flag(dispatch_ready, 1'b1, "dispatch_ready with the station drained");
        end
        if (!saw_full) begin
            stop_with_error("the station never filled up and dispatch_ready never dropped");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+.
ooo_types_pkg.sv
reservation_station.sv
int_alu_unit.sv
mul_unit.sv
cdb_arbiter.sv
ooo_backend.sv
tb_ooo_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the out-of-order back end testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module tb_ooo_backend -o sim_ooo_backend
./obj_dir/sim_ooo_backend | tee sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
